/* build.f */
+incdir+bench
hdl/tilemapPkg.sv
hdl/cpuBusPkg.sv
hdl/tilemapIf.sv
hdl/videoCounter.sv
hdl/accessSequencer.sv
hdl/layerAddrGen.sv
hdl/tilemapAddrTop.sv
bench/tbTop.sv

/* run.sh */
#!/bin/sh
# Compile the tilemap testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f build.f --top-module tbTop -Mdir obj_dir -o tbTop
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/tbTop
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit $status
fi
exit 0

/* bench/tbTests.svh */
////////////////////////////////////////////////////
// Test state and address rules
////////////////////////////////////////////////////

// Scroll values last written, per layer
logic [8:0] scrollXSet [2];
logic [7:0] scrollYSet [2];
// Known beam position of the checked tile
logic [8:0] tileH;
logic [7:0] lineV;
logic flipSet;
// Last CPU write
logic [13:0] writeAddr;
logic [7:0] writeData;

// Scrolled column position, wraps at 512
function automatic logic [8:0] scrolledX(input int layer, input logic [8:0] hPos);
	return (flipSet ? ~hPos : hPos) + scrollXSet[layer];
endfunction

// Scrolled line, wraps at 256
function automatic logic [7:0] scrolledY(input int layer);
	return (flipSet ? ~lineV : lineV) + scrollYSet[layer];
endfunction

// Layer bit, row, column, byte select
function automatic logic [12:0] fetchAddr(input int layer, input logic [8:0] hPos,
		input logic byteSel);
	logic [8:0] sx;
	logic [7:0] sy;
	sx = scrolledX(layer, hPos);
	sy = scrolledY(layer);
	return {layer[0], sy[7:3], sx[8:3], byteSel};
endfunction

// One cycle with latchN low
task automatic writeScroll(input int layer, input logic [1:0] regSel, input logic [7:0] data);
	cpuAddr = {11'd0, layer[0], regSel};
	cpuDataIn = data;
	latchN = 1'b0;
	@(negedge CLK_6M);
	latchN = 1'b1;
endtask

// Sync low one cycle then high one, h restarts on the fall
task automatic syncPulse(input logic frame);
	hSyncN = 1'b0;
	vSyncN = !frame;
	@(negedge CLK_6M);
	hSyncN = 1'b1;
	vSyncN = 1'b1;
	@(negedge CLK_6M);
endtask

////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////

// Last reset cycle, then one tile with the CPU holding the RAM
task automatic resetState();
	checkValue("resetState", 32'd1, 32'(ramWeN));
	checkValue("resetState", 32'd1, 32'(ramOeN));
	checkValue("resetState", 32'd0, 32'({pixelPhaseA, pixelPhaseB}));
	rstN = 1'b1;
	ramCsN = 1'b0;
	repeat (4) @(negedge CLK_6M);
	// Free slots 4 to 7, no tile word latched yet
	repeat (4) begin
		checkValue("resetState", 32'd0, 32'(gfxAddr));
		@(negedge CLK_6M);
	end
	ramCsN = 1'b1;
endtask

task automatic cpuWrite();
	int lows;
	lows = 0;
	writeAddr = 14'(randomWord());
	writeData = 8'(randomWord());
	cpuAddr = writeAddr;
	cpuDataIn = writeData;
	ramCsN = 1'b0;
	rnW = 1'b0;
	// One write held for three cycles
	for (int n = 0; n < 3; n++) begin
		#1;
		checkValue("cpuWrite", 32'(n != 0), 32'(ramWeN));
		checkValue("cpuWrite", 32'(writeAddr[12:0]), 32'(ramAddr));
		checkValue("cpuWrite", 32'(writeData), 32'(ramDataOut));
		@(negedge CLK_6M);
	end
	rnW = 1'b1;
	@(negedge CLK_6M);
	// Second write, one more strobe only
	writeData = writeData ^ 8'h5a;
	cpuDataIn = writeData;
	rnW = 1'b0;
	for (int n = 0; n < 3; n++) begin
		#1;
		lows = lows + (ramWeN ? 0 : 1);
		@(negedge CLK_6M);
	end
	checkValue("cpuWrite", 32'd1, 32'(lows));
	rnW = 1'b1;
	ramCsN = 1'b1;
endtask

task automatic cpuRead();
	logic [13:0] addr;
	logic [7:0] expected;
	// Byte just written, then a random one
	for (int n = 0; n < 2; n++) begin
		addr = (n == 0) ? writeAddr : 14'(randomWord());
		expected = (n == 0) ? writeData : tileRam[addr[12:1]][addr[0]];
		cpuAddr = addr;
		ramCsN = 1'b0;
		rnW = 1'b1;
		#1;
		checkValue("cpuRead", 32'd0, 32'(ramOeN));
		checkValue("cpuRead", 32'd1, 32'(ramWeN));
		checkValue("cpuRead", 32'(expected), 32'(cpuDataOut));
		@(negedge CLK_6M);
	end
	ramCsN = 1'b1;
endtask

task automatic scrolledFetch(input string name, input logic flipOn);
	logic [31:0] r;
	int waited;
	for (int layer = 0; layer < 2; layer++) begin
		r = randomWord();
		scrollXSet[layer] = r[8:0];
		scrollYSet[layer] = r[16:9];
		writeScroll(layer, 2'd0, r[7:0]);
		// high byte, bit 0 only counts
		writeScroll(layer, 2'd1, {r[23:17], r[8]});
		writeScroll(layer, 2'd2, r[16:9]);
		// Select code 3 has no register behind it
		writeScroll(layer, 2'd3, ~r[7:0]);
	end
	flip = flipOn;
	flipSet = flipOn;
	r = randomWord();
	lineV = {2'b00, r[5:0]};
	// Frame start, then line pulses up to the chosen v
	syncPulse(1'b1);
	repeat (r[5:0]) syncPulse(1'b0);
	// Layer B attribute slot marks h at 3
	for (waited = 0; waited < 16 && !(ramAddr[12] && ramAddr[0]); waited++)
		@(negedge CLK_6M);
	if (!(ramAddr[12] && ramAddr[0]))
		abortRun("Timeout waiting for the layer B attribute slot after line sync");
	// h is 1 after the pulse, so slot 3 comes two cycles later
	checkValue(name, 32'd2, 32'(waited));
	// Skip a random number of tiles
	tileH = {6'(r[11:6] + 6'd1), 3'd0};
	repeat (5 + 8 * int'(r[11:6])) @(negedge CLK_6M);
	for (int s = 0; s < 4; s++) begin
		checkValue(name, 32'(fetchAddr(s / 2, tileH + 9'(s), s[0])), 32'(ramAddr));
		@(negedge CLK_6M);
	end
endtask

// Runs from slot 4, layer A then layer B on the ROM bus
task automatic gfxAddress(input string name);
	logic [12:0] codeAddr;
	logic [12:0] attrAddr;
	logic [7:0] codeByte;
	logic [7:0] attrByte;
	logic [8:0] hPos;
	logic [8:0] sx;
	logic [7:0] sy;
	for (int layer = 0; layer < 2; layer++) begin
		codeAddr = fetchAddr(layer, tileH + 9'(2 * layer), 1'b0);
		attrAddr = fetchAddr(layer, tileH + 9'(2 * layer + 1), 1'b1);
		codeByte = tileRam[codeAddr[12:1]][codeAddr[0]];
		attrByte = tileRam[attrAddr[12:1]][attrAddr[0]];
		sy = scrolledY(layer);
		hPos = tileH + 9'(4 + layer);
		checkValue(name, 32'({attrByte[2:0], codeByte, sy[2:0]}), 32'(gfxAddr));
		sx = scrolledX(0, hPos);
		checkValue(name, 32'(sx[2]), 32'(pixelPhaseA));
		sx = scrolledX(1, hPos);
		checkValue(name, 32'(sx[2]), 32'(pixelPhaseB));
		@(negedge CLK_6M);
	end
endtask

/* bench/tbTop.sv */
`timescale 1ns/100ps

module tbTop;

	logic CLK_6M;
	logic rstN;
	logic hSyncN;
	logic vSyncN;
	logic flip;
	logic latchN;
	logic ramCsN;
	logic rnW;
	logic [13:0] cpuAddr;
	logic [7:0] cpuDataIn;
	logic [7:0] cpuDataOut;
	logic [7:0] ramDataIn;
	logic [7:0] ramDataOut;
	logic [12:0] ramAddr;
	logic ramWeN;
	logic ramOeN;
	logic [13:0] gfxAddr;
	logic pixelPhaseA;
	logic pixelPhaseB;

	// Tile RAM, code byte at index 0, attribute at 1
	logic [7:0] tileRam [4096][2];
	logic [31:0] rngState;

	tilemapAddrTop dut0 (.*);

	always #5 CLK_6M = ~CLK_6M;

	// Asynchronous read of the muxed address
	assign ramDataIn = tileRam[ramAddr[12:1]][ramAddr[0]];

	// Write enable taken like a synchronous RAM
	always @(posedge CLK_6M) begin
		if (!ramWeN)
			tileRam[ramAddr[12:1]][ramAddr[0]] <= ramDataOut;
	end

	// Xorshift32 step
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic logic [31:0] randomWord();
		rngState = xorshift(rngState);
		return rngState;
	endfunction

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Regression failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic checkValue(input string testName, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (expected === actual) else begin
			abortRun($sformatf("CHECK FAILED %s: expected %0h, actual %0h",
				testName, expected, actual));
		end
	endtask

	`include "tbTests.svh"

	initial begin
		CLK_6M = 1'b0;
		rstN = 1'b0;
		hSyncN = 1'b1;
		vSyncN = 1'b1;
		flip = 1'b0;
		latchN = 1'b1;
		ramCsN = 1'b1;
		rnW = 1'b1;
		cpuAddr = '0;
		cpuDataIn = '0;
		rngState = 32'd36781;
		// Random tile words over both layers
		for (int i = 0; i < 4096; i++) begin
			tileRam[i][0] = 8'(randomWord());
			tileRam[i][1] = 8'(randomWord());
		end
		repeat (5) @(negedge CLK_6M);
		resetState();
		cpuWrite();
		cpuRead();
		// Plain scroll, then mirrored
		repeat (4) begin
			scrolledFetch("scrolledFetch", 1'b0);
			gfxAddress("gfxAddress");
		end
		repeat (4) begin
			scrolledFetch("flipMode", 1'b1);
			gfxAddress("flipMode");
		end
		$display("Regression passed");
		$finish;
	end

endmodule

/* hdl/tilemapAddrTop.sv */
`timescale 1ns/100ps

module tilemapAddrTop (
	input logic CLK_6M,
	input logic rstN,
	input logic hSyncN,
	input logic vSyncN,
	input logic flip,
	input logic latchN,
	input logic ramCsN,
	input logic rnW,
	input logic [cpuBusPkg::cpuAddrWidth-1:0] cpuAddr,
	input logic [cpuBusPkg::dataWidth-1:0] cpuDataIn,
	output logic [cpuBusPkg::dataWidth-1:0] cpuDataOut,
	input logic [cpuBusPkg::dataWidth-1:0] ramDataIn,
	output logic [cpuBusPkg::dataWidth-1:0] ramDataOut,
	output logic [tilemapPkg::ramAddrWidth-1:0] ramAddr,
	output logic ramWeN,
	output logic ramOeN,
	output logic [tilemapPkg::gfxAddrWidth-1:0] gfxAddr,
	output logic pixelPhaseA,
	output logic pixelPhaseB
);

	videoTimingIf timing ();
	scrollWriteIf scrollBus ();
	fetchCtrlIf fetchBus ();

	// Per-layer addresses into the muxes
	logic [tilemapPkg::ramAddrWidth-1:0] layerARamAddr;
	logic [tilemapPkg::ramAddrWidth-1:0] layerBRamAddr;
	logic [tilemapPkg::gfxAddrWidth-1:0] layerAGfxAddr;
	logic [tilemapPkg::gfxAddrWidth-1:0] layerBGfxAddr;

	// Scroll bus straight from the CPU pins
	assign scrollBus.write = ~latchN;
	assign scrollBus.layerSel = cpuAddr[2];
	assign scrollBus.regSel = cpuAddr[1:0];
	assign scrollBus.data = cpuDataIn;

	videoCounter counter0 (.CLK_6M, .rstN, .hSyncN, .vSyncN, .flip, .timing(timing.counter));

	accessSequencer sequencer0 (
		.CLK_6M, .rstN,
		.timing(timing.sequencer), .fetch(fetchBus.sequencer),
		.ramCsN, .rnW, .cpuAddr, .cpuDataIn, .cpuDataOut,
		.ramDataIn, .ramDataOut, .ramAddr, .ramWeN, .ramOeN,
		.layerARamAddr, .layerBRamAddr, .layerAGfxAddr, .layerBGfxAddr,
		.gfxAddr
	);

	// Layer A sits in the low half of tile RAM
	layerAddrGen #(.assignedLayer(0)) layerA (
		.CLK_6M, .rstN,
		.timing(timing.layer), .scroll(scrollBus.layer), .fetch(fetchBus.layer),
		.ramDataIn, .ramAddr(layerARamAddr), .gfxAddr(layerAGfxAddr),
		.pixelPhase(pixelPhaseA)
	);

	layerAddrGen #(.assignedLayer(1)) layerB (
		.CLK_6M, .rstN,
		.timing(timing.layer), .scroll(scrollBus.layer), .fetch(fetchBus.layer),
		.ramDataIn, .ramAddr(layerBRamAddr), .gfxAddr(layerBGfxAddr),
		.pixelPhase(pixelPhaseB)
	);

endmodule

/* hdl/layerAddrGen.sv */
`timescale 1ns/100ps

module layerAddrGen #(
	parameter int assignedLayer = 0
) (
	input logic CLK_6M,
	input logic rstN,
	videoTimingIf.layer timing,
	scrollWriteIf.layer scroll,
	fetchCtrlIf.layer fetch,
	input logic [cpuBusPkg::dataWidth-1:0] ramDataIn,
	output logic [tilemapPkg::ramAddrWidth-1:0] ramAddr,
	output logic [tilemapPkg::gfxAddrWidth-1:0] gfxAddr,
	output logic pixelPhase
);

	// Scroll registers, X is 9 bits
	logic [tilemapPkg::hWidth-1:0] scrollX;
	logic [tilemapPkg::vWidth-1:0] scrollY;
	// Effective and scrolled beam position
	logic [tilemapPkg::hWidth-1:0] eh;
	logic [tilemapPkg::vWidth-1:0] ev;
	logic [tilemapPkg::hWidth-1:0] sx;
	logic [tilemapPkg::vWidth-1:0] sy;
	// Tile word latch
	logic [cpuBusPkg::dataWidth-1:0] codeByte;
	logic [tilemapPkg::tileCodeWidth-1:0] tileCode;
	logic writeHit;
	logic ownSlot;
	logic byteSel;

	////////////////////////////////////////////////////
	// Scroll registers
	////////////////////////////////////////////////////

	assign writeHit = scroll.write && (scroll.layerSel == 1'(assignedLayer));

	always_ff @(posedge CLK_6M) begin
		if (!rstN) begin
			scrollX <= '0;
			scrollY <= '0;
		end else if (writeHit) begin
			case (cpuBusPkg::scrollReg'(scroll.regSel))
				cpuBusPkg::scrollXLo: scrollX[7:0] <= scroll.data;
				// Only bit 0 of the high byte is kept
				cpuBusPkg::scrollXHi: scrollX[8] <= scroll.data[0];
				cpuBusPkg::scrollY: scrollY <= scroll.data;
				default: ;
			endcase
		end
	end

	////////////////////////////////////////////////////
	// Tile RAM address
	////////////////////////////////////////////////////

	// Flip mirrors both axes
	assign eh = timing.flip ? ~timing.h : timing.h;
	assign ev = timing.flip ? ~timing.v : timing.v;
	// Wraps at 512 and 256
	assign sx = eh + scrollX;
	assign sy = ev + scrollY;

	// Attribute byte sits at the odd address
	assign byteSel = (fetch.slot == tilemapPkg::aAttr) || (fetch.slot == tilemapPkg::bAttr);
	assign ramAddr = {1'(assignedLayer), sy[7:3], sx[8:3], byteSel};

	////////////////////////////////////////////////////
	// Tile word latch and ROM address
	////////////////////////////////////////////////////

	assign ownSlot = (fetch.activeLayer == 1'(assignedLayer));

	// Code first, whole word taken with the attribute
	always_ff @(posedge CLK_6M) begin
		if (!rstN) begin
			codeByte <= '0;
			tileCode <= '0;
		end else if (ownSlot && fetch.codeStrobe)
			codeByte <= ramDataIn;
		else if (ownSlot && fetch.attrStrobe)
			tileCode <= {ramDataIn[2:0], codeByte};
	end

	// Fine row from the scrolled line
	assign gfxAddr = {tileCode, sy[2:0]};
	// Half-tile phase for the pixel shifter
	assign pixelPhase = sx[2];

	// Unused select code must leave the scroll state alone
	assert property (@(posedge CLK_6M) disable iff (!rstN)
		(scroll.write && scroll.regSel == 2'd3) |=> $stable({scrollX, scrollY}));

endmodule

/* hdl/accessSequencer.sv */
`timescale 1ns/100ps

module accessSequencer (
	input logic CLK_6M,
	input logic rstN,
	videoTimingIf.sequencer timing,
	fetchCtrlIf.sequencer fetch,
	input logic ramCsN,
	input logic rnW,
	input logic [cpuBusPkg::cpuAddrWidth-1:0] cpuAddr,
	input logic [cpuBusPkg::dataWidth-1:0] cpuDataIn,
	output logic [cpuBusPkg::dataWidth-1:0] cpuDataOut,
	input logic [cpuBusPkg::dataWidth-1:0] ramDataIn,
	output logic [cpuBusPkg::dataWidth-1:0] ramDataOut,
	output logic [tilemapPkg::ramAddrWidth-1:0] ramAddr,
	output logic ramWeN,
	output logic ramOeN,
	input logic [tilemapPkg::ramAddrWidth-1:0] layerARamAddr,
	input logic [tilemapPkg::ramAddrWidth-1:0] layerBRamAddr,
	input logic [tilemapPkg::gfxAddrWidth-1:0] layerAGfxAddr,
	input logic [tilemapPkg::gfxAddrWidth-1:0] layerBGfxAddr,
	output logic [tilemapPkg::gfxAddrWidth-1:0] gfxAddr
);

	cpuBusPkg::cpuWriteState cpuState;
	cpuBusPkg::cpuWriteState writePhase;
	logic cpuWrite;
	logic fetchSlotUsed;

	////////////////////////////////////////////////////
	// Fetch slot decode
	////////////////////////////////////////////////////

	// Slot is the pixel within the tile
	assign fetch.slot = tilemapPkg::fetchSlot'(timing.h[2:0]);
	// Slots 0 and 1 go to layer A, 2 and 3 to layer B
	assign fetch.activeLayer = timing.h[1];
	assign fetchSlotUsed = !timing.h[2];
	// CPU access steals the slot, so no latching then
	assign fetch.codeStrobe = ramCsN &&
		(fetch.slot == tilemapPkg::aCode || fetch.slot == tilemapPkg::bCode);
	assign fetch.attrStrobe = ramCsN &&
		(fetch.slot == tilemapPkg::aAttr || fetch.slot == tilemapPkg::bAttr);

	////////////////////////////////////////////////////
	// CPU write FSM
	////////////////////////////////////////////////////

	assign cpuWrite = !ramCsN && !rnW;

	// First cycle of a write is the strobe cycle
	always_comb begin
		writePhase = cpuState;
		if (cpuState == cpuBusPkg::idle && cpuWrite)
			writePhase = cpuBusPkg::writing;
	end

	// Hold until the CPU lets go of the write
	always_ff @(posedge CLK_6M) begin
		if (!rstN)
			cpuState <= cpuBusPkg::idle;
		else if (cpuWrite)
			cpuState <= cpuBusPkg::held;
		else
			cpuState <= cpuBusPkg::idle;
	end

	assign ramWeN = (writePhase != cpuBusPkg::writing);
	assign ramOeN = ramCsN || !ramWeN;
	// Data just passes between the buses
	assign ramDataOut = cpuDataIn;
	assign cpuDataOut = ramDataIn;

	// Address muxes, CPU always has priority
	always_comb begin
		if (!ramCsN)
			ramAddr = cpuAddr[tilemapPkg::ramAddrWidth-1:0];
		else if (fetchSlotUsed && fetch.activeLayer)
			ramAddr = layerBRamAddr;
		else
			ramAddr = layerARamAddr;
	end

	// ROM side alternates layers every pixel
	assign gfxAddr = timing.h[0] ? layerBGfxAddr : layerAGfxAddr;

	// RAM is never driven both ways
	assert property (@(posedge CLK_6M) disable iff (!rstN) !(!ramWeN && !ramOeN));
	assert property (@(posedge CLK_6M) disable iff (!rstN)
		!(fetch.codeStrobe && fetch.attrStrobe));
	// Line start must open a tile period
	assert property (@(posedge CLK_6M) disable iff (!rstN)
		timing.lineStart |-> fetch.slot == tilemapPkg::aCode);

endmodule

/* hdl/videoCounter.sv */
`timescale 1ns/100ps

module videoCounter (
	input logic CLK_6M,
	input logic rstN,
	input logic hSyncN,
	input logic vSyncN,
	input logic flip,
	videoTimingIf.counter timing
);

	// Previous sync samples for edge detection
	logic hSyncPrev;
	logic vSyncPrev;
	logic hFall;
	logic vFall;

	assign hFall = hSyncPrev && !hSyncN;
	assign vFall = vSyncPrev && !vSyncN;

	////////////////////////////////////////////////////
	// Sync edge detect and beam counters
	////////////////////////////////////////////////////

	always_ff @(posedge CLK_6M) begin
		if (!rstN) begin
			// Syncs idle high
			hSyncPrev <= 1'b1;
			vSyncPrev <= 1'b1;
			timing.h <= '0;
			timing.v <= '0;
			timing.flip <= 1'b0;
			timing.lineStart <= 1'b0;
		end else begin
			hSyncPrev <= hSyncN;
			vSyncPrev <= vSyncN;
			// Line start lines up with h at 0
			timing.lineStart <= hFall;
			if (hFall) begin
				timing.h <= '0;
				// Flip only changes between lines
				timing.flip <= flip;
			end else
				timing.h <= timing.h + 1'b1;
			// Frame reset wins over line step
			if (vFall)
				timing.v <= '0;
			else if (hFall)
				timing.v <= timing.v + 1'b1;
		end
	end

endmodule

/* hdl/tilemapIf.sv */
`timescale 1ns/100ps

// Beam position shared by the sequencer and both layers
interface videoTimingIf;
	logic [tilemapPkg::hWidth-1:0] h;
	logic [tilemapPkg::vWidth-1:0] v;
	// Flip level, held for a whole line
	logic flip;
	// One-cycle pulse while h is 0
	logic lineStart;

	modport counter (output h, v, flip, lineStart);
	modport sequencer (input h, lineStart);
	modport layer (input h, v, flip, lineStart);
endinterface

// Scroll register writes from the CPU
interface scrollWriteIf;
	// Level, rewrites every cycle it is high
	logic write;
	// Layer select, cpuAddr[2]
	logic layerSel;
	// Register select, cpuAddr[1:0]
	logic [1:0] regSel;
	logic [cpuBusPkg::dataWidth-1:0] data;

	modport layer (input write, layerSel, regSel, data);
endinterface

// RAM fetch slot control
interface fetchCtrlIf;
	tilemapPkg::fetchSlot slot;
	// Latch enables, the byte is taken at the edge closing the slot
	logic codeStrobe;
	logic attrStrobe;
	// Layer that owns the current fetch slot
	logic activeLayer;

	modport sequencer (output slot, codeStrobe, attrStrobe, activeLayer);
	modport layer (input slot, codeStrobe, attrStrobe, activeLayer);
endinterface

/* hdl/cpuBusPkg.sv */
package cpuBusPkg;

	////////////////////////////////////////////////////
	// CPU side of the tilemap chip
	////////////////////////////////////////////////////

	// CPU address and data bus widths
	localparam int cpuAddrWidth = 14;
	localparam int dataWidth = 8;

	// Scroll register select from cpuAddr[1:0]
	// Code 3 has no register behind it
	typedef enum logic [1:0] {
		scrollXLo = 2'd0,
		scrollXHi = 2'd1,
		scrollY = 2'd2
	} scrollReg;

	// CPU write FSM
	// writing only lasts for the strobe cycle
	typedef enum logic [1:0] {
		idle, writing, held
	} cpuWriteState;

endpackage

/* hdl/tilemapPkg.sv */
package tilemapPkg;

	////////////////////////////////////////////////////
	// Screen geometry
	////////////////////////////////////////////////////

	// Horizontal beam count, one step per pixel clock
	localparam int hWidth = 9;

	// Visible vertical count
	localparam int vWidth = 8;

	////////////////////////////////////////////////////
	// Tile RAM and graphics ROM
	////////////////////////////////////////////////////

	// Layer bit, 5-bit row, 6-bit column, byte select
	localparam int ramAddrWidth = 13;

	// Tile code then 3-bit fine row
	localparam int gfxAddrWidth = 14;

	// Code byte plus low 3 attribute bits
	localparam int tileCodeWidth = 11;

	// Eight pixel clocks per tile, one RAM slot each
	typedef enum logic [2:0] {
		aCode, aAttr, bCode, bAttr, free4, free5, free6, free7
	} fetchSlot;

endpackage
